// File: Makefile
TOP := tb_dcache_spm_front

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f

# The log decides pass or fail, so the grep status is the run status
run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_dcache_spm_front.sv
// Data cache front end testbench
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache_spm_front;
    import dcache_addr_pkg::*;
    import dcache_port_pkg::*;

    localparam int NUM_PHASES = 6;
    localparam int ARB_PHASE = 4;
    localparam logic [31:0] RSP_MASK = 32'hA5A5_A5A5;

    // One stimulus row with its expected response
    typedef struct packed {
        logic [2:0]  phase;
        logic        port;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [3:0]  ways;
        logic [31:0] rdata;
        logic        err;
    } row_t;

    // Accepted request still waiting for its response
    typedef struct packed {
        int row;
        int cyc;
    } exp_t;

    logic                           clk_i = 1'b0;
    logic                           rst_i;
    way_mask_t                      spm_ways_i;
    port_req_t [`DC_NUM_PORTS-1:0]  core_req_i;
    logic [`DC_NUM_PORTS-1:0]       core_valid_i;
    logic [`DC_NUM_PORTS-1:0]       core_ready_o;
    port_rsp_t [`DC_NUM_PORTS-1:0]  core_rsp_o;
    logic [`DC_NUM_PORTS-1:0]       core_rsp_valid_o;
    port_req_t [`DC_NUM_PORTS-1:0]  cache_req_o;
    logic [`DC_NUM_PORTS-1:0]       cache_valid_o;
    logic [`DC_NUM_PORTS-1:0]       cache_ready_i = '0;
    port_rsp_t [`DC_NUM_PORTS-1:0]  cache_rsp_i = '0;
    logic [`DC_NUM_PORTS-1:0]       cache_rsp_valid_i = '0;

    row_t                           tbl [$];
    exp_t                           exp_q [`DC_NUM_PORTS][$];
    int                             drv_row [`DC_NUM_PORTS];
    logic [`DC_NUM_PORTS-1:0]       acc_valid = '0;
    logic [`DC_NUM_PORTS-1:0][31:0] acc_addr = '0;
    int                             cycle = 0;
    int                             limit = 0;
    int                             checks = 0;
    int                             errors = 0;
    int                             cur_phase = -1;

    dcache_spm_front i_dcache_spm_front (
        .clk_i             ( clk_i             ),
        .rst_i             ( rst_i             ),
        .spm_ways_i        ( spm_ways_i        ),
        .core_req_i        ( core_req_i        ),
        .core_valid_i      ( core_valid_i      ),
        .core_ready_o      ( core_ready_o      ),
        .core_rsp_o        ( core_rsp_o        ),
        .core_rsp_valid_o  ( core_rsp_valid_o  ),
        .cache_req_o       ( cache_req_o       ),
        .cache_valid_o     ( cache_valid_o     ),
        .cache_ready_i     ( cache_ready_i     ),
        .cache_rsp_i       ( cache_rsp_i       ),
        .cache_rsp_valid_i ( cache_rsp_valid_i )
    );

    always #4 clk_i = ~clk_i;

    function automatic bit in_window(input logic [31:0] addr);
        return addr >= `DSPM_BASE && addr < `DSPM_BASE + `DSPM_LENGTH;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Next level answers with the address scrambled by a fixed mask
    task automatic add_cache_row(input int ph, input int port, input int we,
                                 input logic [31:0] addr);
        row_t r;
        r.phase = 3'(ph);
        r.port  = 1'(port);
        r.we    = 1'(we);
        r.addr  = addr;
        r.wdata = ~addr;
        r.be    = 4'hF;
        r.ways  = 4'hF;
        r.rdata = addr ^ RSP_MASK;
        r.err   = 1'b0;
        tbl.push_back(r);
    endtask

    task automatic add_spm_row(input int ph, input int port, input int we,
                               input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] be, input logic [3:0] ways,
                               input logic [31:0] rdata, input int err);
        row_t r;
        r.phase = 3'(ph);
        r.port  = 1'(port);
        r.we    = 1'(we);
        r.addr  = addr;
        r.wdata = wdata;
        r.be    = be;
        r.ways  = ways;
        r.rdata = rdata;
        r.err   = 1'(err);
        tbl.push_back(r);
    endtask

    // --------------------------------------------------
    // Stimulus table, phase by phase
    // --------------------------------------------------
    task automatic build_table();
        // Cache reads on both ports, window edges included
        add_cache_row(0, 0, 0, 32'h0000_0100);
        add_cache_row(0, 1, 0, 32'h0FFF_FFFC);
        add_cache_row(0, 0, 0, 32'h1000_0100);
        add_cache_row(0, 1, 0, 32'h8000_0040);
        add_cache_row(0, 0, 0, 32'h2000_0008);
        add_cache_row(0, 1, 0, 32'h0000_3000);
        add_cache_row(0, 0, 0, 32'hFFFF_FFF0);
        // Scratchpad writes, byte merges and read back
        add_spm_row(1, 0, 1, 32'h1000_0004, 32'h1122_3344, 4'hF, 4'hF, 32'h0, 0);
        add_spm_row(1, 0, 1, 32'h1000_0094, 32'hDEAD_BEEF, 4'hF, 4'hF, 32'h0, 0);
        add_spm_row(1, 0, 1, 32'h1000_0094, 32'h0000_5500, 4'h2, 4'hF, 32'h0, 0);
        add_spm_row(1, 0, 0, 32'h1000_0004, 32'h0, 4'hF, 4'hF, 32'h1122_3344, 0);
        add_spm_row(1, 0, 0, 32'h1000_0094, 32'h0, 4'hF, 4'hF, 32'hDEAD_55EF, 0);
        add_spm_row(1, 1, 1, 32'h1000_00FC, 32'hCAFE_F00D, 4'hF, 4'hF, 32'h0, 0);
        add_spm_row(1, 1, 1, 32'h1000_00FC, 32'h7700_0000, 4'h8, 4'hF, 32'h0, 0);
        add_spm_row(1, 1, 0, 32'h1000_00FC, 32'h0, 4'hF, 4'hF, 32'h77FE_F00D, 0);
        // Way 2 taken away from the scratchpad
        add_spm_row(2, 0, 0, 32'h1000_0094, 32'h0, 4'hF, 4'hB, 32'h0, 1);
        add_spm_row(2, 0, 1, 32'h1000_0094, 32'hFFFF_FFFF, 4'hF, 4'hB, 32'h0, 1);
        add_spm_row(2, 1, 0, 32'h1000_0004, 32'h0, 4'hF, 4'hB, 32'h1122_3344, 0);
        add_spm_row(3, 0, 0, 32'h1000_0094, 32'h0, 4'hF, 4'hF, 32'hDEAD_55EF, 0);
        // Both ports in the same cycle
        add_spm_row(4, 0, 0, 32'h1000_0004, 32'h0, 4'hF, 4'hF, 32'h1122_3344, 0);
        add_spm_row(4, 1, 0, 32'h1000_00FC, 32'h0, 4'hF, 4'hF, 32'h77FE_F00D, 0);
        // Cache and scratchpad mixed on one port
        add_cache_row(5, 1, 0, 32'h0000_0400);
        add_spm_row(5, 1, 0, 32'h1000_0004, 32'h0, 4'hF, 4'hF, 32'h1122_3344, 0);
        add_cache_row(5, 1, 1, 32'h0000_0500);
        add_spm_row(5, 1, 1, 32'h1000_0048, 32'h0BAD_F00D, 4'hF, 4'hF, 32'h0, 0);
        add_spm_row(5, 1, 0, 32'h1000_0048, 32'h0, 4'hF, 4'hF, 32'h0BAD_F00D, 0);
        add_cache_row(5, 1, 0, 32'h4000_0000);
        add_cache_row(5, 0, 0, 32'h0000_0600);
    endtask

    task automatic drive_port(input int p, input int ph);
        for (int i = 0; i < tbl.size(); i++) begin
            if (int'(tbl[i].phase) == ph && int'(tbl[i].port) == p) begin
                drv_row[p]          = i;
                spm_ways_i          = tbl[i].ways;
                core_req_i[p].we    = tbl[i].we;
                core_req_i[p].addr  = tbl[i].addr;
                core_req_i[p].wdata = tbl[i].wdata;
                core_req_i[p].be    = tbl[i].be;
                core_valid_i[p]     = 1'b1;
                // Ready seen here means a handshake at the next edge
                do begin
                    @(negedge clk_i);
                end while (!core_ready_o[p]);
                @(posedge clk_i);
                #1;
            end
        end
        core_valid_i[p] = 1'b0;
    endtask

    task automatic record_handshake(input int p);
        exp_t e;
        e.row = drv_row[p];
        e.cyc = cycle;
        exp_q[p].push_back(e);
    endtask

    task automatic check_rsp(input int p);
        exp_t e;
        row_t r;
        if (exp_q[p].size() == 0) begin
            errors++;
            $display("Error at %0t ns: port %0d answered with no request outstanding", $time, p);
        end else begin
            e = exp_q[p].pop_front();
            r = tbl[e.row];
            check_val($sformatf("port %0d row %0d rdata", p, e.row), core_rsp_o[p].rdata, r.rdata);
            check_val($sformatf("port %0d row %0d err", p, e.row),
                      32'(core_rsp_o[p].err), 32'(r.err));
            check_val($sformatf("port %0d row %0d latency", p, e.row),
                      cycle - e.cyc, in_window(r.addr) ? 2 : 1);
        end
    endtask

    // Forwarded request leaves unchanged, and only for addresses outside the window
    task automatic check_cache_req(input int p);
        row_t r;
        r = tbl[drv_row[p]];
        check_val($sformatf("port %0d row %0d cache route", p, drv_row[p]),
                  32'(in_window(r.addr)), 32'(0));
        check_val($sformatf("port %0d row %0d cache addr", p, drv_row[p]),
                  cache_req_o[p].addr, r.addr);
        check_val($sformatf("port %0d row %0d cache wdata", p, drv_row[p]),
                  cache_req_o[p].wdata, r.wdata);
        check_val($sformatf("port %0d row %0d cache be", p, drv_row[p]),
                  32'(cache_req_o[p].be), 32'(r.be));
        check_val($sformatf("port %0d row %0d cache we", p, drv_row[p]),
                  32'(cache_req_o[p].we), 32'(r.we));
    endtask

    // --------------------------------------------------
    // Cache side responder, one cycle behind the handshake
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h2365_cc84));
        forever begin
            @(posedge clk_i);
            #1;
            for (int p = 0; p < `DC_NUM_PORTS; p++) begin
                cache_ready_i[p]     = ($urandom() % 4) != 0;
                cache_rsp_valid_i[p] = acc_valid[p];
                cache_rsp_i[p].rdata = acc_valid[p] ? acc_addr[p] ^ RSP_MASK : '0;
                cache_rsp_i[p].err   = 1'b0;
            end
        end
    end

    // Sampling mid cycle, where every signal has settled
    always @(negedge clk_i) begin
        cycle++;
        for (int p = 0; p < `DC_NUM_PORTS; p++) begin
            acc_valid[p] = cache_valid_o[p] && cache_ready_i[p];
            acc_addr[p]  = cache_req_o[p].addr;
        end
        if (cycle > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end else if (!rst_i) begin
            for (int p = 0; p < `DC_NUM_PORTS; p++) begin
                if (core_rsp_valid_o[p]) begin
                    check_rsp(p);
                end
                if (cache_valid_o[p]) begin
                    check_cache_req(p);
                end
                if (core_valid_i[p] && core_ready_o[p]) begin
                    record_handshake(p);
                end
            end
            // Port 0 wins a scratchpad collision
            if (cur_phase == ARB_PHASE && core_valid_i == 2'b11) begin
                check_val("arbitration grant", 32'(core_ready_o), 32'(2'b01));
            end
        end
    end

    initial begin
        rst_i        = 1'b1;
        spm_ways_i   = 4'hF;
        core_req_i   = '0;
        core_valid_i = '0;
        build_table();
        limit = tbl.size() * 20 + 100;
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        for (int ph = 0; ph < NUM_PHASES; ph++) begin
            cur_phase = ph;
            fork
                drive_port(0, ph);
                drive_port(1, ph);
            join
            while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
                @(negedge clk_i);
            end
            @(posedge clk_i);
            #1;
        end
        repeat (4) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_port_pkg.sv
src/port_router.sv
src/dspm_ctrl.sv
src/spm_way_array.sv
src/dcache_spm_front.sv
bench/tb_dcache_spm_front.sv

// File: src/dcache_addr_pkg.sv
// Address layout types
`default_nettype none
`include "dcache_consts.svh"

package dcache_addr_pkg;

    // Cache view, tag above a word index and byte offset
    typedef struct packed {
        logic [`DC_ADDR_WIDTH-$clog2(`DC_NUM_ROWS)-3:0] tag;
        logic [$clog2(`DC_NUM_ROWS)-1:0]                index;
        logic [1:0]                                     offset;
    } cache_addr_t;

    // Scratchpad view, the way sits right above the row
    typedef struct packed {
        logic [`DC_ADDR_WIDTH-$clog2(`DC_NUM_WAYS)-$clog2(`DC_NUM_ROWS)-3:0] upper;
        logic [$clog2(`DC_NUM_WAYS)-1:0]                                     way;
        logic [$clog2(`DC_NUM_ROWS)-1:0]                                     row;
        logic [1:0]                                                          offset;
    } spm_addr_t;

    // One address word, read either way
    typedef union packed {
        cache_addr_t cache;
        spm_addr_t   spm;
    } dc_addr_u;

    typedef logic [`DC_NUM_WAYS-1:0] way_mask_t;

    typedef enum logic {
        DEST_CACHE = 1'b0,
        DEST_DSPM  = 1'b1
    } req_dest_t;

endpackage

`default_nettype wire

// File: src/dcache_consts.svh
// Data cache front end constants
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define DC_ADDR_WIDTH 32
`define DC_DATA_WIDTH 32

// --------------------------------------------------
// Way array geometry
// --------------------------------------------------
`define DC_NUM_WAYS 4
// Words per way, one word per row
`define DC_NUM_ROWS 16
// Core request ports, load and store
`define DC_NUM_PORTS 2

// Scratchpad window, ways x rows x 4 bytes
`define DSPM_BASE 32'h1000_0000
`define DSPM_LENGTH 256

`endif

// File: src/dcache_port_pkg.sv
// Core and cache port types
`default_nettype none
`include "dcache_consts.svh"

package dcache_port_pkg;

    // --------------------------------------------------
    // Core and cache side
    // --------------------------------------------------

    // Full address arrives with the request
    typedef struct packed {
        logic                          we;
        dcache_addr_pkg::dc_addr_u     addr;
        logic [`DC_DATA_WIDTH-1:0]     wdata;
        logic [`DC_DATA_WIDTH/8-1:0]   be;
    } port_req_t;

    // One response per request, reads and writes alike
    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0] rdata;
        logic                      err;
    } port_rsp_t;

    // --------------------------------------------------
    // Scratchpad controller side
    // --------------------------------------------------

    // Request tagged with the port it came from
    typedef struct packed {
        port_req_t req;
        logic      port;
    } spm_req_t;

endpackage

`default_nettype wire

// File: src/dcache_spm_front.sv
// Data cache front end top
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_spm_front (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  dcache_addr_pkg::way_mask_t                     spm_ways_i,
    // Core side
    input  dcache_port_pkg::port_req_t [`DC_NUM_PORTS-1:0] core_req_i,
    input  logic [`DC_NUM_PORTS-1:0]                       core_valid_i,
    output logic [`DC_NUM_PORTS-1:0]                       core_ready_o,
    output dcache_port_pkg::port_rsp_t [`DC_NUM_PORTS-1:0] core_rsp_o,
    output logic [`DC_NUM_PORTS-1:0]                       core_rsp_valid_o,
    // Next level cache side
    output dcache_port_pkg::port_req_t [`DC_NUM_PORTS-1:0] cache_req_o,
    output logic [`DC_NUM_PORTS-1:0]                       cache_valid_o,
    input  logic [`DC_NUM_PORTS-1:0]                       cache_ready_i,
    input  dcache_port_pkg::port_rsp_t [`DC_NUM_PORTS-1:0] cache_rsp_i,
    input  logic [`DC_NUM_PORTS-1:0]                       cache_rsp_valid_i
);
    import dcache_addr_pkg::*;
    import dcache_port_pkg::*;

    // Router to scratchpad controller
    port_req_t [`DC_NUM_PORTS-1:0]          spm_req;
    logic [`DC_NUM_PORTS-1:0]               spm_valid;
    logic [`DC_NUM_PORTS-1:0]               spm_ready;
    port_rsp_t [`DC_NUM_PORTS-1:0]          spm_rsp;
    logic [`DC_NUM_PORTS-1:0]               spm_rsp_valid;

    // Controller to way array
    way_mask_t                              mem_req;
    logic                                   mem_we;
    logic [$clog2(`DC_NUM_ROWS)-1:0]        mem_row;
    logic [`DC_DATA_WIDTH-1:0]              mem_wdata;
    logic [`DC_DATA_WIDTH/8-1:0]            mem_be;
    logic [`DC_NUM_WAYS-1:0][`DC_DATA_WIDTH-1:0] mem_rdata;

    // --------------------------------------------------
    // Per-port address routing
    // --------------------------------------------------
    for (genvar p = 0; p < `DC_NUM_PORTS; p++) begin : g_port
        port_router i_port_router (
            .clk_i             ( clk_i                ),
            .rst_i             ( rst_i                ),
            .core_req_i        ( core_req_i[p]        ),
            .core_valid_i      ( core_valid_i[p]      ),
            .core_ready_o      ( core_ready_o[p]      ),
            .core_rsp_o        ( core_rsp_o[p]        ),
            .core_rsp_valid_o  ( core_rsp_valid_o[p]  ),
            .cache_req_o       ( cache_req_o[p]       ),
            .cache_valid_o     ( cache_valid_o[p]     ),
            .cache_ready_i     ( cache_ready_i[p]     ),
            .cache_rsp_i       ( cache_rsp_i[p]       ),
            .cache_rsp_valid_i ( cache_rsp_valid_i[p] ),
            .spm_req_o         ( spm_req[p]           ),
            .spm_valid_o       ( spm_valid[p]         ),
            .spm_ready_i       ( spm_ready[p]         ),
            .spm_rsp_i         ( spm_rsp[p]           ),
            .spm_rsp_valid_i   ( spm_rsp_valid[p]     )
        );
    end

    // --------------------------------------------------
    // Scratchpad on the way array
    // --------------------------------------------------
    dspm_ctrl i_dspm_ctrl (
        .clk_i       ( clk_i         ),
        .rst_i       ( rst_i         ),
        .spm_ways_i  ( spm_ways_i    ),
        .req_i       ( spm_req       ),
        .valid_i     ( spm_valid     ),
        .ready_o     ( spm_ready     ),
        .rsp_o       ( spm_rsp       ),
        .rsp_valid_o ( spm_rsp_valid ),
        .mem_req_o   ( mem_req       ),
        .mem_we_o    ( mem_we        ),
        .mem_row_o   ( mem_row       ),
        .mem_wdata_o ( mem_wdata     ),
        .mem_be_o    ( mem_be        ),
        .mem_rdata_i ( mem_rdata     )
    );

    spm_way_array i_spm_way_array (
        .clk_i   ( clk_i     ),
        .req_i   ( mem_req   ),
        .we_i    ( mem_we    ),
        .row_i   ( mem_row   ),
        .wdata_i ( mem_wdata ),
        .be_i    ( mem_be    ),
        .rdata_o ( mem_rdata )
    );

endmodule

`default_nettype wire

// File: src/dspm_ctrl.sv
// Data scratchpad controller
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dspm_ctrl (
    input  logic                                              clk_i,
    input  logic                                              rst_i,
    input  dcache_addr_pkg::way_mask_t                        spm_ways_i,
    // Router side
    input  dcache_port_pkg::port_req_t [`DC_NUM_PORTS-1:0]    req_i,
    input  logic [`DC_NUM_PORTS-1:0]                          valid_i,
    output logic [`DC_NUM_PORTS-1:0]                          ready_o,
    output dcache_port_pkg::port_rsp_t [`DC_NUM_PORTS-1:0]    rsp_o,
    output logic [`DC_NUM_PORTS-1:0]                          rsp_valid_o,
    // Way array side
    output dcache_addr_pkg::way_mask_t                        mem_req_o,
    output logic                                              mem_we_o,
    output logic [$clog2(`DC_NUM_ROWS)-1:0]                   mem_row_o,
    output logic [`DC_DATA_WIDTH-1:0]                         mem_wdata_o,
    output logic [`DC_DATA_WIDTH/8-1:0]                       mem_be_o,
    input  logic [`DC_NUM_WAYS-1:0][`DC_DATA_WIDTH-1:0]       mem_rdata_i
);
    import dcache_addr_pkg::*;
    import dcache_port_pkg::*;

    localparam int unsigned WAY_W = $clog2(`DC_NUM_WAYS);

    logic                     lower_valid;
    logic [`DC_NUM_PORTS-1:0] gnt;
    spm_req_t                 sel_req;

    logic                     s1_valid_q;
    spm_req_t                 s1_req_q;
    spm_addr_t                s1_addr;
    logic                     s1_owned;

    logic                     s2_valid_q;
    logic                     s2_port_q;
    logic                     s2_we_q;
    logic                     s2_err_q;
    logic [WAY_W-1:0]         s2_way_q;

    // --------------------------------------------------
    // Fixed priority, lowest port wins
    // --------------------------------------------------
    always_comb begin
        lower_valid = 1'b0;
        sel_req     = '0;
        for (int p = 0; p < `DC_NUM_PORTS; p++) begin
            ready_o[p] = !lower_valid;
            if (valid_i[p] && !lower_valid) begin
                sel_req.req  = req_i[p];
                sel_req.port = 1'(p);
            end
            lower_valid = lower_valid || valid_i[p];
        end
    end

    assign gnt = valid_i & ready_o;

    // --------------------------------------------------
    // Stage 1 drives the array
    // --------------------------------------------------
    assign s1_addr  = s1_req_q.req.addr.spm;
    assign s1_owned = spm_ways_i[s1_addr.way];

    // Unowned ways are never touched
    assign mem_req_o   = (s1_valid_q && s1_owned) ? way_mask_t'(1 << s1_addr.way) : '0;
    assign mem_we_o    = s1_req_q.req.we;
    assign mem_row_o   = s1_addr.row;
    assign mem_wdata_o = s1_req_q.req.wdata;
    assign mem_be_o    = s1_req_q.req.be;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= |gnt;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (|gnt) begin
            s1_req_q <= sel_req;
        end
        s2_port_q <= s1_req_q.port;
        s2_we_q   <= s1_req_q.req.we;
        s2_err_q  <= !s1_owned;
        s2_way_q  <= s1_addr.way;
    end

    // --------------------------------------------------
    // Stage 2 picks the way and returns to its port
    // --------------------------------------------------
    always_comb begin
        for (int p = 0; p < `DC_NUM_PORTS; p++) begin
            rsp_valid_o[p] = s2_valid_q && (s2_port_q == 1'(p));
            rsp_o[p].err   = s2_err_q;
            // Writes and errors return zero data
            rsp_o[p].rdata = (s2_err_q || s2_we_q) ? '0 : mem_rdata_i[s2_way_q];
        end
    end

    // A single grant, answered on its own port two edges later
    assert property (@(posedge clk_i) disable iff (rst_i)
        |gnt |-> $onehot0(gnt) ##2 (rsp_valid_o == $past(gnt, 2)));

    // Array access is one-hot and stays inside the owned ways
    assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(mem_req_o) && ((mem_req_o & ~spm_ways_i) == '0));

endmodule

`default_nettype wire

// File: src/port_router.sv
// Core port address router
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module port_router (
    input  logic                       clk_i,
    input  logic                       rst_i,
    // Core side
    input  dcache_port_pkg::port_req_t core_req_i,
    input  logic                       core_valid_i,
    output logic                       core_ready_o,
    output dcache_port_pkg::port_rsp_t core_rsp_o,
    output logic                       core_rsp_valid_o,
    // Next level cache side
    output dcache_port_pkg::port_req_t cache_req_o,
    output logic                       cache_valid_o,
    input  logic                       cache_ready_i,
    input  dcache_port_pkg::port_rsp_t cache_rsp_i,
    input  logic                       cache_rsp_valid_i,
    // Scratchpad controller side
    output dcache_port_pkg::port_req_t spm_req_o,
    output logic                       spm_valid_o,
    input  logic                       spm_ready_i,
    input  dcache_port_pkg::port_rsp_t spm_rsp_i,
    input  logic                       spm_rsp_valid_i
);
    import dcache_addr_pkg::*;

    localparam int unsigned TAG_LSB = $clog2(`DC_NUM_ROWS) + 2;
    localparam logic [`DC_ADDR_WIDTH-1:0] WIN_BASE = `DSPM_BASE;
    localparam logic [`DC_ADDR_WIDTH-1:0] WIN_END = `DSPM_BASE + `DSPM_LENGTH;

    dc_addr_u   req_addr;
    req_dest_t  req_dest;
    req_dest_t  out_dest_q;
    logic [1:0] out_cnt_q;
    logic       dest_free;
    logic       fire;

    // Window decode on the tag, as the window is tag aligned
    assign req_addr = core_req_i.addr;
    assign req_dest = (req_addr.cache.tag >= WIN_BASE[`DC_ADDR_WIDTH-1:TAG_LSB] &&
                       req_addr.cache.tag < WIN_END[`DC_ADDR_WIDTH-1:TAG_LSB])
                      ? DEST_DSPM : DEST_CACHE;

    // Switching sides waits until the other side has drained
    assign dest_free = (out_cnt_q == 2'd0) ||
                       (out_dest_q == req_dest && out_cnt_q != 2'd3);

    assign cache_req_o   = core_req_i;
    assign spm_req_o     = core_req_i;
    assign cache_valid_o = core_valid_i && dest_free && (req_dest == DEST_CACHE);
    assign spm_valid_o   = core_valid_i && dest_free && (req_dest == DEST_DSPM);
    assign core_ready_o  = (cache_valid_o && cache_ready_i) || (spm_valid_o && spm_ready_i);
    assign fire          = core_valid_i && core_ready_o;

    // Only one side can have responses outstanding
    assign core_rsp_valid_o = cache_rsp_valid_i || spm_rsp_valid_i;
    assign core_rsp_o       = spm_rsp_valid_i ? spm_rsp_i : cache_rsp_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_cnt_q  <= 2'd0;
            out_dest_q <= DEST_CACHE;
        end else begin
            if (fire && !core_rsp_valid_o) begin
                out_cnt_q <= out_cnt_q + 2'd1;
            end else if (!fire && core_rsp_valid_o) begin
                out_cnt_q <= out_cnt_q - 2'd1;
            end
            if (fire) begin
                out_dest_q <= req_dest;
            end
        end
    end

    // Counter never wraps past three
    assert property (@(posedge clk_i) disable iff (rst_i)
        (fire && !core_rsp_valid_o) |=> (out_cnt_q != 2'd0));

    // Responses only from the side that owns the outstanding requests
    assert property (@(posedge clk_i) disable iff (rst_i)
        core_rsp_valid_o |-> (out_cnt_q != 2'd0) && !(cache_rsp_valid_i && spm_rsp_valid_i) &&
                             (spm_rsp_valid_i == (out_dest_q == DEST_DSPM)));

endmodule

`default_nettype wire

// File: src/spm_way_array.sv
// Scratchpad way memory banks
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module spm_way_array (
    input  logic                                        clk_i,
    // One request bit per way, the rest is shared
    input  logic [`DC_NUM_WAYS-1:0]                     req_i,
    input  logic                                        we_i,
    input  logic [$clog2(`DC_NUM_ROWS)-1:0]             row_i,
    input  logic [`DC_DATA_WIDTH-1:0]                   wdata_i,
    input  logic [`DC_DATA_WIDTH/8-1:0]                 be_i,
    output logic [`DC_NUM_WAYS-1:0][`DC_DATA_WIDTH-1:0] rdata_o
);

    // --------------------------------------------------
    // One bank per way
    // --------------------------------------------------
    for (genvar w = 0; w < `DC_NUM_WAYS; w++) begin : g_way
        logic [`DC_DATA_WIDTH-1:0] bank_q [`DC_NUM_ROWS];
        logic [`DC_DATA_WIDTH-1:0] rdata_q;

        always_ff @(posedge clk_i) begin
            if (req_i[w]) begin
                if (we_i) begin
                    // Byte lanes merge into the stored word
                    for (int b = 0; b < `DC_DATA_WIDTH/8; b++) begin
                        if (be_i[b]) begin
                            bank_q[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                end else begin
                    rdata_q <= bank_q[row_i];
                end
            end
        end

        // Read word holds until the next read of this way
        assign rdata_o[w] = rdata_q;
    end

endmodule

`default_nettype wire
